/* mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// first fetch address after reset
// the instruction memory also uses it as its base, addresses are taken modulo this value
`define MIPS_RESET_VECTOR 32'hBFC00000

// instruction memory depth in 32-bit words
`define MIPS_IRAM_WORDS 4096

// data memory depth in 32-bit words
// covers the load area at 0x0 and the store area at 0x100
`define MIPS_DRAM_WORDS 1024

// architectural register count
// r0 reads as zero, r2 is v0
`define MIPS_REG_COUNT 32

`endif

/* mips_bus_pkg.sv */
package mips_bus_pkg;

    // one data or instruction word
    typedef logic [31:0] word_t;

    // byte address on the fetch and data buses
    // the low two bits are ignored, all accesses are word wide
    typedef logic [31:0] addr_t;

    // index into the register file
    typedef logic [4:0] reg_idx_t;

endpackage

/* mips_isa_pkg.sv */
package mips_isa_pkg;

    // primary opcode field, only the supported subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_ADDIU = 6'b001001,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    // funct field of r-type words
    // jr is the only one decoded
    typedef enum logic [5:0] {
        FN_JR = 6'b001000
    } funct_t;

    // immediate format, used by lw, sw and addiu
    typedef struct packed {
        opcode_t                opcode;
        mips_bus_pkg::reg_idx_t rs;
        mips_bus_pkg::reg_idx_t rt;
        logic [15:0]            imm;
    } itype_t;

    // register format, used by jr
    typedef struct packed {
        opcode_t                opcode;
        mips_bus_pkg::reg_idx_t rs;
        mips_bus_pkg::reg_idx_t rt;
        mips_bus_pkg::reg_idx_t rd;
        logic [4:0]             shamt;
        funct_t                 funct;
    } rtype_t;

endpackage

/* sb_1_iram.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module sb_1_iram (
    // combinational read of instruction words
    input  mips_bus_pkg::addr_t instr_address,
    output mips_bus_pkg::word_t instr_readdata
);

    localparam int IRAM_AW = $clog2(`MIPS_IRAM_WORDS);

    mips_bus_pkg::word_t instr_ram [0:`MIPS_IRAM_WORDS-1];

    // offset from the reset vector
    mips_bus_pkg::addr_t offset;

    assign offset = instr_address % `MIPS_RESET_VECTOR;

    initial begin
        int                   i;
        mips_bus_pkg::addr_t  w_addr;
        mips_isa_pkg::itype_t iw;
        mips_isa_pkg::rtype_t rw;

        // unused words decode as sll r0, r0, 0 which does nothing
        for (int k = 0; k < `MIPS_IRAM_WORDS; k++) begin
            instr_ram[k] = '0;
        end

        // program starts at offset 0, i.e. the reset vector
        w_addr = '0;

        // lw ri, (i-2)*4(r0) for r2 to r16
        for (i = 2; i <= 16; i++) begin
            iw.opcode = mips_isa_pkg::OP_LW;
            iw.rs     = '0;
            iw.rt     = mips_bus_pkg::reg_idx_t'(i);
            iw.imm    = 16'((i - 2) * 4);
            instr_ram[w_addr[IRAM_AW+1:2]] = iw;
            w_addr += 4;
        end

        // sw ri, 0x100 + (i-2)*4(r0) for r2 to r15
        for (i = 2; i <= 15; i++) begin
            iw.opcode = mips_isa_pkg::OP_SW;
            iw.rs     = '0;
            iw.rt     = mips_bus_pkg::reg_idx_t'(i);
            iw.imm    = 16'(16'h100 + (i - 2) * 4);
            instr_ram[w_addr[IRAM_AW+1:2]] = iw;
            w_addr += 4;
        end

        // jr r0, so the pc reaches 0 after the delay slot and the core halts
        rw.opcode = mips_isa_pkg::OP_RTYPE;
        rw.rs     = '0;
        rw.rt     = '0;
        rw.rd     = '0;
        rw.shamt  = '0;
        rw.funct  = mips_isa_pkg::FN_JR;
        instr_ram[w_addr[IRAM_AW+1:2]] = rw;
        w_addr += 4;

        // delay slot: addiu r2, r0, 0 clears v0
        iw.opcode = mips_isa_pkg::OP_ADDIU;
        iw.rs     = '0;
        iw.rt     = 5'd2;
        iw.imm    = '0;
        instr_ram[w_addr[IRAM_AW+1:2]] = iw;
    end

    always_comb begin
        instr_readdata = instr_ram[offset[IRAM_AW+1:2]];
    end

endmodule

/* mips_regfile.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module mips_regfile (
    input  logic                   clk,
    input  logic                   rst,
    // two combinational read ports
    input  mips_bus_pkg::reg_idx_t read_index_a,
    input  mips_bus_pkg::reg_idx_t read_index_b,
    output mips_bus_pkg::word_t    read_data_a,
    output mips_bus_pkg::word_t    read_data_b,
    // one write port, lands on the rising edge
    input  logic                   write_enable,
    input  mips_bus_pkg::reg_idx_t write_index,
    input  mips_bus_pkg::word_t    write_data,
    output mips_bus_pkg::word_t    register_v0
);

    mips_bus_pkg::word_t regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `MIPS_REG_COUNT; k++) begin
                regs[k] <= '0;
            end
        end else if (write_enable && write_index != '0) begin
            // r0 is never written so it keeps reading zero
            regs[write_index] <= write_data;
        end
    end

    assign read_data_a = regs[read_index_a];
    assign read_data_b = regs[read_index_b];

    // v0 is r2
    assign register_v0 = regs[2];

endmodule

/* mips_data_ram.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module mips_data_ram (
    input  logic                clk,
    input  logic                rst,
    // loader port, only honoured while the core is in reset
    input  logic                preload_write,
    input  mips_bus_pkg::addr_t preload_address,
    input  mips_bus_pkg::word_t preload_data,
    // core port
    input  mips_bus_pkg::addr_t data_address,
    input  logic                data_write,
    input  mips_bus_pkg::word_t data_writedata,
    output mips_bus_pkg::word_t data_readdata
);

    localparam int DRAM_AW = $clog2(`MIPS_DRAM_WORDS);

    mips_bus_pkg::word_t mem [0:`MIPS_DRAM_WORDS-1];

    // selected write source
    logic                wr_en;
    mips_bus_pkg::addr_t wr_addr;
    mips_bus_pkg::word_t wr_data;

    // the core owns the port once reset is released
    always_comb begin
        if (rst) begin
            wr_en   = preload_write;
            wr_addr = preload_address;
            wr_data = preload_data;
        end else begin
            wr_en   = data_write;
            wr_addr = data_address;
            wr_data = data_writedata;
        end
    end

    // word addressed, byte offset bits dropped
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[DRAM_AW+1:2]] <= wr_data;
        end
    end

    assign data_readdata = mem[data_address[DRAM_AW+1:2]];

endmodule

/* mips_core.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module mips_core (
    input  logic                   clk,
    input  logic                   rst,
    // fetch
    output mips_bus_pkg::addr_t    instr_address,
    input  mips_bus_pkg::word_t    instr_readdata,
    // register file
    output mips_bus_pkg::reg_idx_t read_index_a,
    output mips_bus_pkg::reg_idx_t read_index_b,
    input  mips_bus_pkg::word_t    read_data_a,
    input  mips_bus_pkg::word_t    read_data_b,
    output logic                   reg_write,
    output mips_bus_pkg::reg_idx_t write_index,
    output mips_bus_pkg::word_t    write_data,
    // data memory
    output mips_bus_pkg::addr_t    data_address,
    output logic                   data_write,
    output mips_bus_pkg::word_t    data_writedata,
    input  mips_bus_pkg::word_t    data_readdata,
    output logic                   active
);

    // program counter and the jump waiting behind the delay slot
    mips_bus_pkg::addr_t pc;
    logic                jump_pending;
    mips_bus_pkg::addr_t jump_target;

    // the fetched word seen in both formats
    mips_isa_pkg::itype_t instr_i;
    mips_isa_pkg::rtype_t instr_r;

    logic is_lw;
    logic is_sw;
    logic is_addiu;
    logic is_jr;

    // executing this cycle
    logic run;

    mips_bus_pkg::word_t imm_ext;
    mips_bus_pkg::word_t sum;

    assign instr_i = mips_isa_pkg::itype_t'(instr_readdata);
    assign instr_r = mips_isa_pkg::rtype_t'(instr_readdata);

    assign is_lw    = instr_i.opcode == mips_isa_pkg::OP_LW;
    assign is_sw    = instr_i.opcode == mips_isa_pkg::OP_SW;
    assign is_addiu = instr_i.opcode == mips_isa_pkg::OP_ADDIU;
    assign is_jr    = instr_r.opcode == mips_isa_pkg::OP_RTYPE &&
                      instr_r.funct == mips_isa_pkg::FN_JR;

    // pc 0 is the halt address the program jumps to
    // nothing executes while in reset either
    assign run    = !rst && pc != '0;
    assign active = run;

    assign instr_address = pc;

    // rs feeds the adder and the jump target, rt is the store data
    assign read_index_a = instr_i.rs;
    assign read_index_b = instr_i.rt;

    // one adder serves both the lw/sw address and addiu
    assign imm_ext = {{16{instr_i.imm[15]}}, instr_i.imm};
    assign sum     = read_data_a + imm_ext;

    assign data_address   = sum;
    assign data_writedata = read_data_b;
    assign data_write     = run && is_sw;

    // lw and addiu both write rt
    assign reg_write   = run && (is_lw || is_addiu);
    assign write_index = instr_i.rt;
    assign write_data  = is_lw ? data_readdata : sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= `MIPS_RESET_VECTOR;
            jump_pending <= 1'b0;
            jump_target  <= '0;
        end else if (run) begin
            // a jump from the previous cycle lands after this delay slot
            if (jump_pending) begin
                pc           <= jump_target;
                jump_pending <= 1'b0;
            end else begin
                pc <= pc + 32'd4;
            end
            // jr only records the target here
            if (is_jr) begin
                jump_pending <= 1'b1;
                jump_target  <= read_data_a;
            end
        end
    end

endmodule

/* mips_top.sv */
`timescale 1ns/10ps

module mips_top (
    input  logic                clk,
    input  logic                rst,
    // data memory loader, used while rst is high
    input  logic                preload_write,
    input  mips_bus_pkg::addr_t preload_address,
    input  mips_bus_pkg::word_t preload_data,
    output logic                active,
    // store bus as seen by the data memory
    output logic                data_write,
    output mips_bus_pkg::addr_t data_address,
    output mips_bus_pkg::word_t data_writedata,
    output mips_bus_pkg::word_t register_v0
);

    // fetch
    mips_bus_pkg::addr_t    instr_address;
    mips_bus_pkg::word_t    instr_readdata;

    // register file
    mips_bus_pkg::reg_idx_t read_index_a;
    mips_bus_pkg::reg_idx_t read_index_b;
    mips_bus_pkg::word_t    read_data_a;
    mips_bus_pkg::word_t    read_data_b;
    logic                   reg_write;
    mips_bus_pkg::reg_idx_t write_index;
    mips_bus_pkg::word_t    write_data;

    // load return path
    mips_bus_pkg::word_t    data_readdata;

    mips_core u_core (
        .clk            (clk),
        .rst            (rst),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .read_index_a   (read_index_a),
        .read_index_b   (read_index_b),
        .read_data_a    (read_data_a),
        .read_data_b    (read_data_b),
        .reg_write      (reg_write),
        .write_index    (write_index),
        .write_data     (write_data),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata),
        .active         (active)
    );

    sb_1_iram u_iram (
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata)
    );

    mips_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .read_index_a (read_index_a),
        .read_index_b (read_index_b),
        .read_data_a  (read_data_a),
        .read_data_b  (read_data_b),
        .write_enable (reg_write),
        .write_index  (write_index),
        .write_data   (write_data),
        .register_v0  (register_v0)
    );

    mips_data_ram u_data_ram (
        .clk             (clk),
        .rst             (rst),
        .preload_write   (preload_write),
        .preload_address (preload_address),
        .preload_data    (preload_data),
        .data_address    (data_address),
        .data_write      (data_write),
        .data_writedata  (data_writedata),
        .data_readdata   (data_readdata)
    );

endmodule

/* mips_top_tb.sv */
`timescale 1ns/10ps
`include "mips_defines.svh"

module mips_top_tb;

    // program shape: 15 loads, 14 stores, jr and its delay slot
    localparam int LOAD_WORDS  = 15;
    localparam int STORE_WORDS = 14;
    localparam int STORE_BASE  = 32'h100;
    localparam int PROG_LEN    = 31;
    localparam int RUN_TIMEOUT = 200;
    localparam int HALT_CYCLES = 50;
    localparam int EXTRA_WORDS = 8;

    logic                clk;
    logic                rst;
    logic                preload_write;
    mips_bus_pkg::addr_t preload_address;
    mips_bus_pkg::word_t preload_data;
    logic                active;
    logic                data_write;
    mips_bus_pkg::addr_t data_address;
    mips_bus_pkg::word_t data_writedata;
    mips_bus_pkg::word_t register_v0;

    // mirror of the data ram and of the register file
    mips_bus_pkg::word_t model_mem [`MIPS_DRAM_WORDS];
    mips_bus_pkg::word_t model_regs [`MIPS_REG_COUNT];
    // v0 just before the delay slot addiu runs
    mips_bus_pkg::word_t v0_before_slot;

    mips_top dut_i (
        .clk             (clk),
        .rst             (rst),
        .preload_write   (preload_write),
        .preload_address (preload_address),
        .preload_data    (preload_data),
        .active          (active),
        .data_write      (data_write),
        .data_address    (data_address),
        .data_writedata  (data_writedata),
        .register_v0     (register_v0)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input mips_bus_pkg::word_t expected,
                              input mips_bus_pkg::word_t actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("[ERROR] %s: expected %h, actual %h",
                                      name, expected, actual));
        end
    endtask

    task automatic check_addr(input string name, input mips_bus_pkg::addr_t expected,
                              input mips_bus_pkg::addr_t actual);
        if (actual !== expected) begin
            stop_on_failure($sformatf("[ERROR] %s: expected %h, actual %h",
                                      name, expected, actual));
        end
    endtask

    // one loader write, driven on the falling edge while rst is high
    task automatic preload_word(input int index, input mips_bus_pkg::word_t value);
        @(negedge clk);
        preload_write    = 1'b1;
        preload_address  = mips_bus_pkg::addr_t'(index * 4);
        preload_data     = value;
        model_mem[index] = value;
        #1;
        if (data_write !== 1'b0) begin
            stop_on_failure("data_write went high while the core was held in reset");
        end
    endtask

    task automatic reset_and_preload();
        int idx;
        @(negedge clk);
        rst           = 1'b1;
        preload_write = 1'b0;
        // plain reset first, the loader follows with rst still high
        repeat (4) begin
            @(negedge clk);
            #1;
            if (data_write !== 1'b0 || active !== 1'b0) begin
                stop_on_failure("data_write or active was high during reset");
            end
        end
        // load area 0x0 to 0x38
        for (int k = 0; k < LOAD_WORDS; k++) begin
            preload_word(k, $urandom());
        end
        // scattered words elsewhere, the store area included
        repeat (EXTRA_WORDS) begin
            idx = LOAD_WORDS + ($urandom() % (`MIPS_DRAM_WORDS - LOAD_WORDS));
            preload_word(idx, $urandom());
        end
    endtask

    // program-level effect of the fixed program on the mirror
    task automatic run_model();
        for (int r = 0; r < `MIPS_REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        // lw r2..r16 from words 0x0..0x38
        for (int i = 2; i <= 16; i++) begin
            model_regs[i] = model_mem[i - 2];
        end
        // sw r2..r15 to 0x100..0x134
        for (int i = 2; i <= 15; i++) begin
            model_mem[STORE_BASE / 4 + i - 2] = model_regs[i];
        end
        v0_before_slot = model_regs[2];
        // addiu r2, r0, 0 in the delay slot
        model_regs[2] = '0;
    endtask

    task automatic run_program(input string tag);
        int                  cycle;
        int                  stores;
        mips_bus_pkg::word_t v0_last;
        cycle   = 0;
        stores  = 0;
        v0_last = '0;
        @(negedge clk);
        preload_write = 1'b0;
        rst           = 1'b0;
        #1;
        // one window per instruction, sampled 1 ns after the falling edge
        while (active === 1'b1) begin
            if (cycle >= RUN_TIMEOUT) begin
                stop_on_failure("timeout: active never fell, the core did not halt");
            end
            if (data_write === 1'b1) begin
                if (cycle < LOAD_WORDS) begin
                    stop_on_failure("a store appeared during the load instructions");
                end
                if (stores >= STORE_WORDS) begin
                    stop_on_failure("more stores appeared than the program holds");
                end
                check_addr($sformatf("%s store %0d address", tag, stores),
                           mips_bus_pkg::addr_t'(STORE_BASE + 4 * stores), data_address);
                // model's copy of the store area after the program
                check_word($sformatf("%s store %0d data", tag, stores),
                           model_mem[STORE_BASE / 4 + stores], data_writedata);
                stores++;
            end
            v0_last = register_v0;
            cycle++;
            @(negedge clk);
            #1;
        end
        if (cycle == 0) begin
            stop_on_failure("active never rose after reset was released");
        end
        check_word({tag, " edges until halt"}, PROG_LEN, cycle);
        check_word({tag, " store count"}, STORE_WORDS, stores);
        // last active window is the delay slot, before addiu lands
        check_word({tag, " v0 before delay slot"}, v0_before_slot, v0_last);
        check_word({tag, " v0 after halt"}, model_regs[2], register_v0);
        // halted core must stay quiet
        repeat (HALT_CYCLES) begin
            @(negedge clk);
            #1;
            if (data_write !== 1'b0) begin
                stop_on_failure("data_write rose after the core had halted");
            end
            if (active !== 1'b0) begin
                stop_on_failure("active rose again while the core was halted");
            end
        end
    endtask

    initial begin
        void'($urandom(32'h4a49_2352));
        clk             = 1'b0;
        rst             = 1'b1;
        preload_write   = 1'b0;
        preload_address = '0;
        preload_data    = '0;
        reset_and_preload();
        run_model();
        run_program("run 1");
        // second reset must restart the pc and clear halt
        reset_and_preload();
        run_model();
        run_program("run 2");
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* mips_top.f */
+incdir+.
mips_bus_pkg.sv
mips_isa_pkg.sv
sb_1_iram.sv
mips_regfile.sv
mips_data_ram.sv
mips_core.sv
mips_top.sv
mips_top_tb.sv
